//--- design/board_pkg.sv
package board_pkg;

    //--------------------------------------------------------------------
    // widths

    localparam w_sample  = 24;  // microphone sample
    localparam w_segment = 8;   // abcdefgh with the dot

    //--------------------------------------------------------------------
    // tm1638 command bytes

    localparam [7:0] tm_cmd_write      = 8'h40;  // data write with auto increment
    localparam [7:0] tm_cmd_addr0      = 8'hC0;  // start at address 0
    localparam [7:0] tm_cmd_display_on = 8'h8F;  // display on at full brightness
    localparam       tm_n_data_bytes   = 16;     // digit and led bytes interleaved

    //--------------------------------------------------------------------

    function automatic logic [w_segment - 1:0] hex_to_segments (input logic [3:0] nibble);
        case (nibble)
        4'h0:    return 8'b1111_1100;
        4'h1:    return 8'b0110_0000;
        4'h2:    return 8'b1101_1010;
        4'h3:    return 8'b1111_0010;
        4'h4:    return 8'b0110_0110;
        4'h5:    return 8'b1011_0110;
        4'h6:    return 8'b1011_1110;
        4'h7:    return 8'b1110_0000;
        4'h8:    return 8'b1111_1110;
        4'h9:    return 8'b1111_0110;
        4'ha:    return 8'b1110_1110;
        4'hb:    return 8'b0011_1110;  // lower case b
        4'hc:    return 8'b1001_1100;
        4'hd:    return 8'b0111_1010;  // lower case d
        4'he:    return 8'b1001_1110;
        default: return 8'b1000_1110;  // f
        endcase
    endfunction

endpackage

//--- design/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
# (
    parameter clk_mhz = 100
)
(
    input                                           clk,
    input                                           rst,

    output logic                                    lr,
    output logic                                    ws,
    output logic                                    sck,
    input                                           sd,

    output logic signed [board_pkg::w_sample - 1:0] value,
    output logic                                    valid
);

    import board_pkg::*;

    localparam half_period = clk_mhz / 6 > 0 ? clk_mhz / 6 : 1;  // about 3 MHz sck
    localparam w_div       = half_period > 1 ? $clog2 (half_period) : 1;

    logic [w_div    - 1:0] div_cnt;
    logic                  sck_tick;
    logic                  sck_rise;
    logic                  sck_fall;

    logic [           5:0] bit_cnt;   // sck periods within the frame
    logic [           5:0] bit_cnt_next;

    logic [           1:0] sd_sync;
    logic [w_sample - 1:0] shift;
    logic                  capture;

    //--------------------------------------------------------------------
    // clock generation

    assign lr           = 1'b0;  // mic answers in the left slot
    assign sck_tick     = div_cnt == w_div' (half_period - 1);
    assign sck_rise     = sck_tick & ~ sck;
    assign sck_fall     = sck_tick &   sck;
    assign bit_cnt_next = bit_cnt + 6'd1;

    always_ff @ (posedge clk)
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~ sck;

            if (sck)  // falling edge starts the next period
            begin
                bit_cnt <= bit_cnt_next;
                ws      <= bit_cnt_next [5];
            end
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end

    //--------------------------------------------------------------------
    // data capture

    always_ff @ (posedge clk)
        sd_sync <= { sd_sync [0], sd };

    // msb arrives in the second period after ws falls
    assign capture = sck_rise
                   & ~ ws
                   & (bit_cnt >= 6'd1)
                   & (bit_cnt <= 6' (w_sample));

    always_ff @ (posedge clk)
        if (capture)
            shift <= { shift [w_sample - 2:0], sd_sync [1] };

    always_ff @ (posedge clk)
        if (sck_fall && bit_cnt_next == 6'd32)  // ws about to rise
            value <= shift;

    always_ff @ (posedge clk)
        if (rst)
            valid <= 1'b0;
        else
            valid <= sck_fall && bit_cnt_next == 6'd32;

endmodule

//--- design/key_debouncer.sv
`timescale 1ns/1ps

module key_debouncer
# (
    parameter clk_mhz     = 100,
              debounce_us = 1000,
              w_key       = 2
)
(
    input                      clk,
    input                      rst,
    input        [w_key - 1:0] key_n,   // active low pins
    output logic [w_key - 1:0] press
);

    localparam n_stable = clk_mhz * debounce_us;  // cycles of steady input
    localparam w_cnt    = $clog2 (n_stable + 1);

    generate
        genvar i;

        for (i = 0; i < w_key; i ++)
        begin : gen_key

            logic [      1:0] sync_n;
            logic             pressed;   // synchronized and active high
            logic             level;     // debounced state
            logic [w_cnt-1:0] cnt;
            logic             settle;
            logic             press_q;

            assign pressed = ~ sync_n [1];
            assign settle  = (pressed != level) && (cnt == w_cnt' (n_stable - 1));

            always_ff @ (posedge clk)
                if (rst)
                begin
                    sync_n  <= '1;
                    level   <= 1'b0;
                    cnt     <= '0;
                    press_q <= 1'b0;
                end
                else
                begin
                    sync_n  <= { sync_n [0], key_n [i] };
                    press_q <= settle & pressed;   // only the press edge

                    if (pressed == level)
                        cnt <= '0;                 // bounce restarts the window
                    else if (settle)
                    begin
                        level <= pressed;
                        cnt   <= '0;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end

            assign press [i] = press_q;

        end
    endgenerate

endmodule

//--- design/level_meter.sv
`timescale 1ns/1ps

module level_meter
# (
    parameter w_digit = 8,
              w_led   = 8
)
(
    input                                                  clk,
    input                                                  rst,

    input        signed [board_pkg::w_sample        - 1:0] mic_value,
    input                                                  mic_valid,
    input               [                            1:0]  key_press,

    output logic [w_digit * board_pkg::w_segment - 1:0]    digits_seg,
    output logic [w_led                          - 1:0]    led_bar
);

    import board_pkg::*;

    localparam n_hex = w_sample / 4;  // nibbles shown on the display

    logic [w_sample            - 1:0] magnitude;
    logic [w_sample            - 1:0] peak;
    logic [w_sample            - 1:0] peak_base;
    logic [w_sample            - 1:0] peak_next;
    logic                             freeze;

    logic [w_digit * w_segment - 1:0] digits_live;
    logic [w_led               - 1:0] led_next;

    //--------------------------------------------------------------------
    // magnitude and peak

    always_comb
        if (mic_value == { 1'b1, { (w_sample - 1) { 1'b0 } } })
            magnitude = { 1'b0, { (w_sample - 1) { 1'b1 } } };  // saturate
        else if (mic_value [w_sample - 1])
            magnitude = - mic_value;
        else
            magnitude = mic_value;

    always_comb
    begin
        peak_base = key_press [1] ? '0 : peak;  // clear before the new sample
        peak_next = peak_base;

        if (mic_valid && magnitude > peak_base)
            peak_next = magnitude;
    end

    //--------------------------------------------------------------------
    // display images

    always_comb
        for (int d = 0; d < w_digit; d ++)
            if (d < n_hex)
                digits_live [d * w_segment +: w_segment] = hex_to_segments (magnitude [d * 4 +: 4]);
            else
                digits_live [d * w_segment +: w_segment] = '0;  // blank

    // led i lights at 2 ** (3i + 2)
    always_comb
        for (int i = 0; i < w_led; i ++)
            led_next [i] = (peak_next >> (3 * i + 2)) != '0;

    //--------------------------------------------------------------------

    always_ff @ (posedge clk)
        if (rst)
        begin
            freeze     <= 1'b0;
            peak       <= '0;
            led_bar    <= '0;
            digits_seg <= '0;
        end
        else
        begin
            if (key_press [0])
                freeze <= ~ freeze;

            peak    <= peak_next;
            led_bar <= led_next;   // peak tracks even when frozen

            if (mic_valid && ! freeze)
                digits_seg <= digits_live;
        end

endmodule

//--- design/tm1638_board_controller.sv
`timescale 1ns/1ps

module tm1638_board_controller
# (
    parameter clk_mhz = 100,
              w_digit = 8,
              w_led   = 8
)
(
    input                                              clk,
    input                                              rst,

    input        [w_digit * board_pkg::w_segment - 1:0] digits_seg,
    input        [w_led                          - 1:0] led_bar,

    output logic                                       sio_clk,
    output logic                                       sio_stb,
    output logic                                       sio_data
);

    import board_pkg::*;

    localparam half_period = clk_mhz / 2 > 0 ? clk_mhz / 2 : 1;  // about 1 MHz sio_clk
    localparam w_div       = half_period > 1 ? $clog2 (half_period) : 1;
    localparam n_pos       = tm_n_data_bytes / 2;
    localparam w_pos       = $clog2 (n_pos);
    localparam w_byte_idx  = $clog2 (tm_n_data_bytes + 1);

    typedef enum logic [1:0]
    {
        st_load,       // strobe goes low
        st_clk_low,    // present the next bit
        st_clk_high,   // board samples here
        st_stop        // strobe goes high
    }
    state_t;

    state_t                           state;
    logic [w_div               - 1:0] div_cnt;
    logic                             tick;
    logic [                      1:0] group;      // 0 write, 1 address and data, 2 display
    logic [w_byte_idx          - 1:0] byte_idx;
    logic [                      2:0] bit_cnt;
    logic                             last_byte;
    logic [w_pos               - 1:0] pos;
    logic [                      7:0] cur_byte;

    logic [w_digit * w_segment - 1:0] snap_seg;
    logic [w_led               - 1:0] snap_led;
    logic [                      7:0] pos_seg [n_pos];
    logic [                      7:0] pos_led [n_pos];

    //--------------------------------------------------------------------
    // byte selection

    // address 0 is the leftmost position and tm1638 wants segment a in bit 0
    always_comb
    begin
        logic [w_segment - 1:0] seg;

        for (int p = 0; p < n_pos; p ++)
        begin
            seg = '0;

            if (p < w_digit)
                seg = snap_seg [(w_digit - 1 - p) * w_segment +: w_segment];

            for (int b = 0; b < w_segment; b ++)
                pos_seg [p][b] = seg [w_segment - 1 - b];

            pos_led [p] = (p < w_led) ? { 7'b0, snap_led [p] } : 8'h00;
        end
    end

    assign pos       = w_pos' ((byte_idx - 1'b1) >> 1);
    assign last_byte = (group == 2'd1) ? (byte_idx == w_byte_idx' (tm_n_data_bytes)) : 1'b1;

    always_comb
        case (group)
        2'd1:
            if (byte_idx == '0)
                cur_byte = tm_cmd_addr0;
            else if (byte_idx [0])
                cur_byte = pos_seg [pos];   // odd bytes carry digits
            else
                cur_byte = pos_led [pos];
        2'd2:
            cur_byte = tm_cmd_display_on;
        default:
            cur_byte = tm_cmd_write;
        endcase

    //--------------------------------------------------------------------
    // serial sequencer

    assign tick = div_cnt == w_div' (half_period - 1);

    always_ff @ (posedge clk)
        if (rst)
        begin
            div_cnt  <= '0;
            state    <= st_load;
            group    <= 2'd0;
            byte_idx <= '0;
            bit_cnt  <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_data <= 1'b0;
        end
        else if (! tick)
        begin
            div_cnt <= div_cnt + 1'b1;
        end
        else
        begin
            div_cnt <= '0;

            case (state)
            st_load:
            begin
                sio_stb  <= 1'b0;
                byte_idx <= '0;
                bit_cnt  <= '0;
                state    <= st_clk_low;
            end
            st_clk_low:
            begin
                sio_clk  <= 1'b0;
                sio_data <= cur_byte [bit_cnt];  // lsb first
                state    <= st_clk_high;
            end
            st_clk_high:
            begin
                sio_clk <= 1'b1;
                bit_cnt <= bit_cnt + 1'b1;

                if (bit_cnt != 3'd7)
                    state <= st_clk_low;
                else if (last_byte)
                    state <= st_stop;
                else
                begin
                    byte_idx <= byte_idx + 1'b1;
                    state    <= st_clk_low;
                end
            end
            default:
            begin
                sio_stb <= 1'b1;
                group   <= (group == 2'd2) ? 2'd0 : group + 2'd1;
                state   <= st_load;
            end
            endcase
        end

    // one image per frame
    always_ff @ (posedge clk)
        if (tick && state == st_load && group == 2'd0)
        begin
            snap_seg <= digits_seg;
            snap_led <= led_bar;
        end

endmodule

//--- design/board_specific_top.sv
`timescale 1ns/1ps

module board_specific_top
# (
    parameter clk_mhz     = 100,
              debounce_us = 1000,
              w_key       = 2,
              w_led       = 8,
              w_digit     = 8
)
(
    input                clk,
    input                rst,

    input  [w_key - 1:0] key_n,

    input                mic_sd,
    output               mic_lr,
    output               mic_ws,
    output               mic_sck,

    output               tm_sio_clk,
    output               tm_sio_stb,
    output               tm_sio_data
);

    import board_pkg::*;

    //--------------------------------------------------------------------

    wire signed [w_sample            - 1:0] mic_value;
    wire                                    mic_valid;
    wire        [w_key               - 1:0] key_press;
    wire        [w_digit * w_segment - 1:0] digits_seg;
    wire        [w_led               - 1:0] led_bar;

    //--------------------------------------------------------------------

    inmp441_mic_i2s_receiver
    # (
        .clk_mhz ( clk_mhz )
    )
    i_microphone
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .lr    ( mic_lr    ),
        .ws    ( mic_ws    ),
        .sck   ( mic_sck   ),
        .sd    ( mic_sd    ),
        .value ( mic_value ),
        .valid ( mic_valid )
    );

    key_debouncer
    # (
        .clk_mhz     ( clk_mhz     ),
        .debounce_us ( debounce_us ),
        .w_key       ( w_key       )
    )
    i_debouncer
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .key_n ( key_n     ),
        .press ( key_press )
    );

    level_meter
    # (
        .w_digit ( w_digit ),
        .w_led   ( w_led   )
    )
    i_level_meter
    (
        .clk        ( clk              ),
        .rst        ( rst              ),
        .mic_value  ( mic_value        ),
        .mic_valid  ( mic_valid        ),
        .key_press  ( key_press [1:0]  ),  // freeze and clear
        .digits_seg ( digits_seg       ),
        .led_bar    ( led_bar          )
    );

    tm1638_board_controller
    # (
        .clk_mhz ( clk_mhz ),
        .w_digit ( w_digit ),
        .w_led   ( w_led   )
    )
    i_tm1638
    (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .digits_seg ( digits_seg  ),
        .led_bar    ( led_bar     ),
        .sio_clk    ( tm_sio_clk  ),
        .sio_stb    ( tm_sio_stb  ),
        .sio_data   ( tm_sio_data )
    );

endmodule

//--- testbench/board_specific_top_assert.sv
`timescale 1ns/1ps

module board_specific_top_assert
# (
    parameter w_led = 8
)
(
    input               clk,
    input               rst,
    input               sio_clk,
    input               sio_stb,
    input               sck,
    input               ws,
    input [w_led - 1:0] led_bar
);

    int failures = 0;   // assertion failures so far

    //--------------------------------------------------------------------
    // serial links

    idle_clock_high: assert property (@(posedge clk) disable iff (rst)
        sio_stb |-> sio_clk)
        else
        begin
            failures++;
            $error ("sio_clk is low while sio_stb is high");
        end

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst)
        $changed (ws) |-> $fell (sck))  // ws moves with the falling sck
        else
        begin
            failures++;
            $error ("ws changed without a falling edge of sck");
        end

    stb_after_reset: assert property (@(posedge clk) rst |=> sio_stb)
        else
        begin
            failures++;
            $error ("sio_stb is not high in the cycle after reset");
        end

    //--------------------------------------------------------------------
    // led bar

    led_thermometer: assert property (@(posedge clk) disable iff (rst)
        (led_bar & (led_bar + 1'b1)) == '0)  // one run of lit leds from led 0
        else
        begin
            failures++;
            $error ("led_bar is not a thermometer code");
        end

endmodule

//--- testbench/tb_board_specific_top.sv
`timescale 1ns/1ps

module tb_board_specific_top;

    import board_pkg::*;

    localparam clk_mhz         = 100;
    localparam debounce_us     = 2;
    localparam w_key           = 2;
    localparam w_led           = 8;
    localparam w_digit         = 8;
    localparam n_frame_bytes   = tm_n_data_bytes + 3;   // write, address, data, display
    localparam debounce_cycles = clk_mhz * debounce_us;

    // a step waits up to two display frames, two mic frames and a key press
    localparam frame_cycles    = (clk_mhz / 2) * (n_frame_bytes * 16 + 6);
    localparam i2s_cycles      = (clk_mhz / 6) * 2 * 64;
    localparam step_cycles     = 2 * frame_cycles + 2 * i2s_cycles + 4 * debounce_cycles;
    localparam n_steps         = 11;
    localparam timeout_cycles  = n_steps * step_cycles * 3 / 2;

    logic                  clk;
    logic                  rst;
    logic [w_key    - 1:0] key_n;
    logic                  mic_sd = 1'b0;
    wire                   mic_lr;
    wire                   mic_ws;
    wire                   mic_sck;
    wire                   tm_sio_clk;
    wire                   tm_sio_stb;
    wire                   tm_sio_data;

    int                    errors      = 0;
    int                    cycle_count = 0;

    logic [w_sample - 1:0] exp_shown;    // magnitude on digits 5 to 0
    logic                  exp_live;     // digits carry a sample
    logic [w_sample - 1:0] exp_peak;
    logic                  exp_frozen;

    board_specific_top
    # (
        .clk_mhz     ( clk_mhz     ),
        .debounce_us ( debounce_us ),
        .w_key       ( w_key       ),
        .w_led       ( w_led       ),
        .w_digit     ( w_digit     )
    )
    i_dut
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .key_n       ( key_n       ),
        .mic_sd      ( mic_sd      ),
        .mic_lr      ( mic_lr      ),
        .mic_ws      ( mic_ws      ),
        .mic_sck     ( mic_sck     ),
        .tm_sio_clk  ( tm_sio_clk  ),
        .tm_sio_stb  ( tm_sio_stb  ),
        .tm_sio_data ( tm_sio_data )
    );

    bind board_specific_top board_specific_top_assert # (.w_led (w_led)) i_assert
    (
        .clk     ( clk        ),
        .rst     ( rst        ),
        .sio_clk ( tm_sio_clk ),
        .sio_stb ( tm_sio_stb ),
        .sck     ( mic_sck    ),
        .ws      ( mic_ws     ),
        .led_bar ( led_bar    )
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~ clk;
    end

    //--------------------------------------------------------------------
    // microphone model

    logic [w_sample - 1:0] next_sample;   // word for the next left half
    logic [w_sample - 1:0] tx_word;
    logic                  sck_q;
    logic                  ws_q;
    int                    slot;          // sck period within the frame
    int                    samples_done;

    always @(posedge clk)
        if (rst)
        begin
            sck_q        <= 1'b0;
            ws_q         <= 1'b0;
            slot         <= 0;
            tx_word      <= '0;
            mic_sd       <= 1'b0;
            samples_done <= 0;
        end
        else
        begin
            sck_q <= mic_sck;
            ws_q  <= mic_ws;

            if (mic_ws && ! ws_q)
                samples_done <= samples_done + 1;    // left half is over

            if (sck_q && ! mic_sck)                  // sck fell at the last edge
            begin
                if (ws_q && ! mic_ws)
                begin
                    slot    <= 0;
                    tx_word <= next_sample;
                    mic_sd  <= 1'b0;
                end
                else
                begin
                    slot   <= slot + 1;
                    mic_sd <= (slot < w_sample) ? tx_word [w_sample - 1 - slot] : 1'b0;
                end
            end
        end

    //--------------------------------------------------------------------
    // tm1638 frame decoder

    logic       tm_clk_q;
    logic       tm_stb_q;
    logic [7:0] rx_byte;
    int         rx_bits;
    logic [7:0] grp   [$];
    logic [7:0] build [$];
    int         build_groups;
    int         build_sizes [3];
    logic [7:0] frame [n_frame_bytes];   // last complete frame
    int         frame_sizes [3];
    int         frame_count;

    always @(posedge clk)
    begin
        tm_clk_q <= tm_sio_clk;
        tm_stb_q <= tm_sio_stb;

        if (rst)
        begin
            rx_bits      = 0;
            build_groups = 0;
            grp.delete ();
            frame_count <= 0;
        end
        else
        begin
            if (! tm_sio_stb && ! tm_clk_q && tm_sio_clk)   // board samples here
            begin
                rx_byte = { tm_sio_data, rx_byte [7:1] };  // lsb first
                rx_bits = rx_bits + 1;

                if (rx_bits == 8)
                begin
                    grp.push_back (rx_byte);
                    rx_bits = 0;
                end
            end

            if (! tm_stb_q && tm_sio_stb)
            begin
                if (build_groups == 0)   // groups counted from reset
                begin
                    build           = grp;
                    build_sizes [0] = grp.size ();
                    build_groups    = 1;
                end
                else
                begin
                    build_sizes [build_groups] = grp.size ();
                    foreach (grp [i])
                        build.push_back (grp [i]);
                    build_groups = build_groups + 1;

                    if (build_groups == 3)
                    begin
                        for (int i = 0; i < n_frame_bytes; i ++)
                            frame [i] <= build [i];
                        frame_sizes  <= build_sizes;
                        frame_count  <= frame_count + 1;
                        build_groups  = 0;
                    end
                end

                grp.delete ();
                rx_bits = 0;
            end
        end
    end

    //--------------------------------------------------------------------
    // expected values and checks

    function automatic logic [w_sample - 1:0] magnitude_of (input logic [w_sample - 1:0] v);
        int s;
        s = $signed (v);
        if (s < 0)
            s = - s;
        if (s > 24'h7fffff)
            s = 24'h7fffff;   // most negative value
        return s [w_sample - 1:0];
    endfunction

    function automatic logic [7:0] digit_byte (input int d);
        logic [7:0] seg;
        logic [7:0] rev;
        seg = '0;
        if (exp_live && d < w_sample / 4)
            seg = hex_to_segments (exp_shown [d * 4 +: 4]);
        for (int b = 0; b < 8; b ++)
            rev [b] = seg [7 - b];   // tm1638 has segment a in bit 0
        return rev;
    endfunction

    function automatic logic [7:0] led_byte (input int p);
        return { 7'b0, exp_peak >= (1 << (3 * p + 2)) };
    endfunction

    task automatic fail_run (input string msg);
        errors ++;
        $display ("%s", msg);
        $display ("Verification failed");
        $fatal (1, "stopping at the first error");
    endtask

    task automatic check_value (input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else
            fail_run ($sformatf ("CHECK FAILED %s %s expected %0h actual %0h",
                                 name, what, expected, actual));
    endtask

    task automatic wait_frames (input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target)
            @(posedge clk);
    endtask

    task automatic check_display (input string name, input int n_frames);
        int d;
        wait_frames (n_frames);
        check_value (name, "write command", tm_cmd_write, frame [0]);
        check_value (name, "address command", tm_cmd_addr0, frame [1]);
        check_value (name, "display command", tm_cmd_display_on, frame [n_frame_bytes - 1]);

        for (int p = 0; p < w_digit; p ++)
        begin
            d = w_digit - 1 - p;   // address 0 is the leftmost digit
            check_value (name, $sformatf ("digit %0d", d), digit_byte (d), frame [2 + 2 * p]);
            check_value (name, $sformatf ("led %0d", p), led_byte (p), frame [3 + 2 * p]);
        end
    endtask

    //--------------------------------------------------------------------
    // stimulus

    task automatic send_sample (input logic [w_sample - 1:0] v);
        int                    target;
        logic [w_sample - 1:0] mag;
        next_sample <= v;
        target = samples_done + 2;   // the second left half surely carries v
        while (samples_done < target)
            @(posedge clk);

        mag = magnitude_of (v);
        if (mag > exp_peak)
            exp_peak = mag;
        if (! exp_frozen)
        begin
            exp_shown = mag;
            exp_live  = 1'b1;
        end
    endtask

    task automatic hold_key (input int k, input int n_cycles);
        @(posedge clk);
        key_n [k] <= 1'b0;
        repeat (n_cycles) @(posedge clk);
        key_n [k] <= 1'b1;
        repeat (debounce_cycles + 10) @(posedge clk);   // release settles
    endtask

    task automatic toggle_freeze ();
        hold_key (0, debounce_cycles + 10);
        exp_frozen = ! exp_frozen;
    endtask

    task automatic clear_peak ();
        hold_key (1, debounce_cycles + 10);
        exp_peak = '0;
    endtask

    //--------------------------------------------------------------------
    // directed tests

    task automatic test_reset_frame ();
        check_display ("reset_frame", 1);
        check_value ("reset_frame", "write group bytes", 1, frame_sizes [0]);
        check_value ("reset_frame", "data group bytes", tm_n_data_bytes + 1, frame_sizes [1]);
        check_value ("reset_frame", "display group bytes", 1, frame_sizes [2]);
        check_value ("reset_frame", "mic lr", 0, mic_lr);
    endtask

    task automatic test_positive_sample ();
        logic [w_sample - 1:0] v;
        v = $urandom & 32'h7fffff;
        send_sample (v);
        check_display ("positive_sample", 2);
    endtask

    task automatic test_negative_sample ();
        logic [w_sample - 1:0] v;
        v = $urandom | 32'h800000;   // random negative
        send_sample (v);
        check_display ("negative_sample", 2);
        send_sample (24'h800000);
        check_display ("most_negative", 2);
    endtask

    task automatic test_peak_hold ();
        send_sample (24'h5a0000);
        clear_peak ();
        send_sample (24'h5a0000);
        check_display ("peak_large", 2);
        send_sample (24'h000150);
        check_display ("peak_hold", 2);
        clear_peak ();
        send_sample (24'h000150);
        check_display ("peak_cleared", 2);
    endtask

    task automatic test_freeze ();
        toggle_freeze ();
        send_sample (24'h3c9e07);
        check_display ("freeze_hold", 2);
        toggle_freeze ();
        send_sample (24'h3c9e07);
        check_display ("freeze_release", 2);
    endtask

    task automatic test_short_pulse ();
        hold_key (0, debounce_cycles / 2);   // too short to count
        send_sample (24'h01b2d4);
        check_display ("short_pulse", 2);
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles)
            fail_run ($sformatf ("run timed out after %0d cycles", cycle_count));
    end

    always @(posedge clk)
        if (i_dut.i_assert.failures != 0)
            fail_run ("a bound protocol assertion failed");

    initial
    begin
        void'($urandom (32'h52abf844));
        rst         = 1'b1;
        key_n       = '1;
        next_sample = '0;
        exp_shown   = '0;
        exp_live    = 1'b0;
        exp_peak    = '0;
        exp_frozen  = 1'b0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_reset_frame ();
        test_positive_sample ();
        test_negative_sample ();
        test_peak_hold ();
        test_freeze ();
        test_short_pulse ();

        if (errors == 0)
            $display ("Verification passed");
        else
            $display ("Verification failed");
        $finish;
    end

endmodule

//--- board_specific_top.f
design/board_pkg.sv
design/inmp441_mic_i2s_receiver.sv
design/key_debouncer.sv
design/level_meter.sv
design/tm1638_board_controller.sv
design/board_specific_top.sv
testbench/board_specific_top_assert.sv
testbench/tb_board_specific_top.sv

//--- Bender.yml
package:
  name: board_specific_top

sources:
  - design/board_pkg.sv
  - design/inmp441_mic_i2s_receiver.sv
  - design/key_debouncer.sv
  - design/level_meter.sv
  - design/tm1638_board_controller.sv
  - design/board_specific_top.sv
  - target: test
    files:
      - testbench/board_specific_top_assert.sv
      - testbench/tb_board_specific_top.sv
